// File: src/noc_pkg.sv
package noc_pkg;

	localparam int NUM_PORTS = 4;

	// port indices, also the order of every per-port array.
	localparam int PORT_N = 0;
	localparam int PORT_E = 1;
	localparam int PORT_W = 2;
	localparam int PORT_L = 3;

	localparam int COORD_W   = 4;	// one mesh coordinate.
	localparam int PAYLOAD_W = 8;

	// input buffer geometry.
	localparam int FIFO_DEPTH = 4;
	localparam int PTR_W      = 2;	// log2 of FIFO_DEPTH.

	// node address, x in the upper nibble and y in the lower.
	typedef struct packed {
		logic [COORD_W-1:0] x;
		logic [COORD_W-1:0] y;
	} addr_t;

	// single-flit packet, destination on top.
	typedef struct packed {
		addr_t                dest;
		logic [PAYLOAD_W-1:0] payload;
	} flit_t;

endpackage

// File: src/route_calc.sv
module route_calc (
	input  noc_pkg::addr_t head_addr_i,
	input  logic           head_valid_i,
	input  noc_pkg::addr_t local_addr_i,

	output logic           north_req_o,
	output logic           east_req_o,
	output logic           west_req_o,
	output logic           local_req_o
);

	logic x_gt, x_lt, y_gt, y_eq;

	assign x_gt = (head_addr_i.x > local_addr_i.x);
	assign x_lt = (head_addr_i.x < local_addr_i.x);
	assign y_gt = (head_addr_i.y > local_addr_i.y);
	assign y_eq = (head_addr_i.y == local_addr_i.y);

	// xy order: x has to be settled before y is looked at.
	always_comb begin
		north_req_o = 1'b0;
		east_req_o  = 1'b0;
		west_req_o  = 1'b0;
		local_req_o = 1'b0;
		if (head_valid_i) begin
			if (x_gt) begin
				east_req_o = 1'b1;
			end else if (x_lt) begin
				west_req_o = 1'b1;
			end else if (y_gt) begin
				north_req_o = 1'b1;
			end else if (y_eq) begin
				local_req_o = 1'b1;
			end
			// a destination south of here has no port and raises nothing.
		end
	end

endmodule

// File: src/rr_arbiter3.sv
module rr_arbiter3 (
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic [2:0] req_i,
	input  logic       out_full_i,

	output logic [2:0] grant_o,
	output logic       grant_v_o
);

	logic [1:0] ptr_q;	// requester with top priority.
	logic [1:0] ptr_d;

	// first requester at or after the pointer, wrapping around.
	always_comb begin
		grant_o = 3'b000;
		if (!out_full_i) begin
			case (ptr_q)
				2'd0: begin
					if (req_i[0])      grant_o = 3'b001;
					else if (req_i[1]) grant_o = 3'b010;
					else if (req_i[2]) grant_o = 3'b100;
				end
				2'd1: begin
					if (req_i[1])      grant_o = 3'b010;
					else if (req_i[2]) grant_o = 3'b100;
					else if (req_i[0]) grant_o = 3'b001;
				end
				default: begin
					if (req_i[2])      grant_o = 3'b100;
					else if (req_i[0]) grant_o = 3'b001;
					else if (req_i[1]) grant_o = 3'b010;
				end
			endcase
		end
	end

	assign grant_v_o = |grant_o;

	// pointer moves past the winner.
	always_comb begin
		ptr_d = ptr_q;
		if (grant_o[0])      ptr_d = 2'd1;
		else if (grant_o[1]) ptr_d = 2'd2;
		else if (grant_o[2]) ptr_d = 2'd0;
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ptr_q <= 2'd0;
		end else begin
			ptr_q <= ptr_d;
		end
	end

endmodule

// File: src/edge_controller.sv
module edge_controller (
	input  logic                         clk,
	input  logic                         rst_n_i,
	input  noc_pkg::addr_t               head_addr_i [noc_pkg::NUM_PORTS-1:0],
	input  logic [noc_pkg::NUM_PORTS-1:0] head_valid_i,
	input  noc_pkg::addr_t               local_addr_i,
	input  logic [noc_pkg::NUM_PORTS-1:0] out_full_i,

	output logic [2:0]                   grant_e_o,
	output logic [2:0]                   grant_w_o,
	output logic [2:0]                   grant_l_o,
	output logic [noc_pkg::NUM_PORTS-1:0] grant_v_o,
	output logic [noc_pkg::NUM_PORTS-1:0] pop_o
);

	import noc_pkg::*;

	// requests per output, bits in ascending input order.
	logic       req_n;	// local only.
	logic [2:0] req_e;	// n, w, l.
	logic [2:0] req_w;	// n, e, l.
	logic [2:0] req_l;	// n, e, w.

	route_calc rc_n (
		.head_addr_i (head_addr_i[PORT_N]),
		.head_valid_i(head_valid_i[PORT_N]),
		.local_addr_i,
		.north_req_o (),
		.east_req_o  (req_e[0]),
		.west_req_o  (req_w[0]),
		.local_req_o (req_l[0])
	);

	route_calc rc_e (
		.head_addr_i (head_addr_i[PORT_E]),
		.head_valid_i(head_valid_i[PORT_E]),
		.local_addr_i,
		.north_req_o (),
		.east_req_o  (),
		.west_req_o  (req_w[1]),
		.local_req_o (req_l[1])
	);

	route_calc rc_w (
		.head_addr_i (head_addr_i[PORT_W]),
		.head_valid_i(head_valid_i[PORT_W]),
		.local_addr_i,
		.north_req_o (),
		.east_req_o  (req_e[1]),
		.west_req_o  (),
		.local_req_o (req_l[2])
	);

	route_calc rc_l (
		.head_addr_i (head_addr_i[PORT_L]),
		.head_valid_i(head_valid_i[PORT_L]),
		.local_addr_i,
		.north_req_o (req_n),
		.east_req_o  (req_e[2]),
		.west_req_o  (req_w[2]),
		.local_req_o ()
	);

	// north has a single requester, so no arbiter.
	assign grant_v_o[PORT_N] = req_n & ~out_full_i[PORT_N];

	rr_arbiter3 arb_e (
		.clk, .rst_n_i, .req_i(req_e), .out_full_i(out_full_i[PORT_E]),
		.grant_o(grant_e_o), .grant_v_o(grant_v_o[PORT_E])
	);

	rr_arbiter3 arb_w (
		.clk, .rst_n_i, .req_i(req_w), .out_full_i(out_full_i[PORT_W]),
		.grant_o(grant_w_o), .grant_v_o(grant_v_o[PORT_W])
	);

	rr_arbiter3 arb_l (
		.clk, .rst_n_i, .req_i(req_l), .out_full_i(out_full_i[PORT_L]),
		.grant_o(grant_l_o), .grant_v_o(grant_v_o[PORT_L])
	);

	// a buffer pops when any output takes its head.
	assign pop_o[PORT_N] = grant_e_o[0] | grant_w_o[0] | grant_l_o[0];
	assign pop_o[PORT_E] = grant_w_o[1] | grant_l_o[1];
	assign pop_o[PORT_W] = grant_e_o[1] | grant_l_o[2];
	assign pop_o[PORT_L] = grant_v_o[PORT_N] | grant_e_o[2] | grant_w_o[2];

endmodule

// File: src/flit_fifo.sv
module flit_fifo (
	input  logic           clk,
	input  logic           rst_n_i,
	input  logic           push_i,
	input  noc_pkg::flit_t flit_i,
	input  logic           pop_i,

	output noc_pkg::flit_t head_o,
	output logic           head_valid_o,
	output logic           full_o
);

	import noc_pkg::*;

	flit_t            mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [PTR_W:0]   count_q;	// one bit wider to hold FIFO_DEPTH.
	logic             do_push;
	logic             do_pop;

	assign full_o       = (count_q == (PTR_W+1)'(FIFO_DEPTH));
	assign head_valid_o = (count_q != '0);
	assign head_o       = mem[rd_ptr_q];

	assign do_push = push_i & ~full_o;	// dropped when full.
	assign do_pop  = pop_i & head_valid_o;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr_q] <= flit_i;
		end
	end

	// pointers wrap on their own since the depth is a power of two.
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			count_q <= '0;
		end else begin
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;	// idle, or push and pop together.
			endcase
		end
	end

endmodule

// File: src/output_crossbar.sv
module output_crossbar (
	input  logic                         clk,
	input  logic                         rst_n_i,
	input  noc_pkg::flit_t               head_i [noc_pkg::NUM_PORTS-1:0],
	input  logic [2:0]                   grant_e_i,
	input  logic [2:0]                   grant_w_i,
	input  logic [2:0]                   grant_l_i,
	input  logic [noc_pkg::NUM_PORTS-1:0] grant_v_i,

	output noc_pkg::flit_t               out_flit_o [noc_pkg::NUM_PORTS-1:0],
	output logic [noc_pkg::NUM_PORTS-1:0] out_valid_o
);

	import noc_pkg::*;

	flit_t next_flit [NUM_PORTS-1:0];

	// one-hot select among three heads.
	function automatic flit_t sel3(input logic [2:0] grant, input flit_t a,
		input flit_t b, input flit_t c);
		flit_t f;
		f = '0;
		if (grant[0])      f = a;
		else if (grant[1]) f = b;
		else if (grant[2]) f = c;
		return f;
	endfunction

	always_comb begin
		next_flit[PORT_N] = head_i[PORT_L];	// only local goes north.
		next_flit[PORT_E] = sel3(grant_e_i, head_i[PORT_N], head_i[PORT_W], head_i[PORT_L]);
		next_flit[PORT_W] = sel3(grant_w_i, head_i[PORT_N], head_i[PORT_E], head_i[PORT_L]);
		next_flit[PORT_L] = sel3(grant_l_i, head_i[PORT_N], head_i[PORT_E], head_i[PORT_W]);
	end

	always_ff @(posedge clk) begin
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (grant_v_i[p]) begin
				out_flit_o[p] <= next_flit[p];
			end
		end
	end

	// one-cycle strobe per granted flit.
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			out_valid_o <= '0;
		end else begin
			out_valid_o <= grant_v_i;
		end
	end

endmodule

// File: src/edge_router.sv
module edge_router (
	input  logic                         clk,
	input  logic                         rst_n_i,
	input  noc_pkg::addr_t               local_addr_i,
	input  noc_pkg::flit_t               in_flit_i [noc_pkg::NUM_PORTS-1:0],
	input  logic [noc_pkg::NUM_PORTS-1:0] in_valid_i,
	output logic [noc_pkg::NUM_PORTS-1:0] in_full_o,

	output noc_pkg::flit_t               out_flit_o [noc_pkg::NUM_PORTS-1:0],
	output logic [noc_pkg::NUM_PORTS-1:0] out_valid_o,
	input  logic [noc_pkg::NUM_PORTS-1:0] out_full_i
);

	import noc_pkg::*;

	flit_t                head_flit [NUM_PORTS-1:0];
	addr_t                head_addr [NUM_PORTS-1:0];
	logic [NUM_PORTS-1:0] head_valid;
	logic [NUM_PORTS-1:0] pop;
	logic [2:0]           grant_e, grant_w, grant_l;
	logic [NUM_PORTS-1:0] grant_v;

	for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_in
		flit_fifo fifo (
			.clk,
			.rst_n_i,
			.push_i      (in_valid_i[p]),
			.flit_i      (in_flit_i[p]),
			.pop_i       (pop[p]),
			.head_o      (head_flit[p]),
			.head_valid_o(head_valid[p]),
			.full_o      (in_full_o[p])
		);
		assign head_addr[p] = head_flit[p].dest;	// routing needs only the address.
	end

	edge_controller controller (
		.clk, .rst_n_i,
		.head_addr_i(head_addr), .head_valid_i(head_valid),
		.local_addr_i, .out_full_i,
		.grant_e_o(grant_e), .grant_w_o(grant_w), .grant_l_o(grant_l),
		.grant_v_o(grant_v), .pop_o(pop)
	);

	output_crossbar crossbar (
		.clk, .rst_n_i,
		.head_i(head_flit),
		.grant_e_i(grant_e), .grant_w_i(grant_w), .grant_l_i(grant_l),
		.grant_v_i(grant_v),
		.out_flit_o, .out_valid_o
	);

endmodule

// File: verification/edge_router_asserts.sv
module edge_router_asserts (
	input logic                          clk,
	input logic                          rst_n_i,
	input noc_pkg::addr_t                local_addr_i,
	input noc_pkg::flit_t                head_i [noc_pkg::NUM_PORTS-1:0],
	input logic [noc_pkg::NUM_PORTS-1:0] head_valid_i,
	input logic [noc_pkg::NUM_PORTS-1:0] in_valid_i,
	input logic [noc_pkg::NUM_PORTS-1:0] in_full_i,
	input logic [noc_pkg::NUM_PORTS-1:0] out_valid_i,
	input logic [noc_pkg::NUM_PORTS-1:0] out_full_i,
	input logic [noc_pkg::NUM_PORTS-1:0] grant_v_i,
	input logic [2:0]                    grant_e_i,
	input logic [2:0]                    grant_w_i,
	input logic [2:0]                    grant_l_i
);
	timeunit 1ns;
	timeprecision 100ps;

	import noc_pkg::*;

	int fail_cnt = 0;	// failures seen so far.

	a_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
		$onehot0(grant_e_i) && $onehot0(grant_w_i) && $onehot0(grant_l_i))
	else begin
		$error("a grant vector has more than one bit set");
		fail_cnt++;
	end

	a_full_grant: assert property (@(posedge clk) disable iff (!rst_n_i)
		(grant_v_i & out_full_i) == '0)
	else begin
		$error("an output was granted while its downstream was full");
		fail_cnt++;
	end

	a_full_push: assert property (@(posedge clk) disable iff (!rst_n_i)
		(in_valid_i & in_full_i) == '0)
	else begin
		$error("a flit was pushed into a full input buffer");
		fail_cnt++;
	end

	// nothing south of the edge, and local may not loop back to itself.
	for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_route
		a_route: assert property (@(posedge clk) disable iff (!rst_n_i)
			head_valid_i[p] |-> head_i[p].dest.y >= local_addr_i.y &&
				!(p == PORT_L && head_i[p].dest == local_addr_i))
		else begin
			$error("the head flit of input %0d has no legal route", p);
			fail_cnt++;
		end
	end

	a_reset: assert property (@(posedge clk)
		$rose(rst_n_i) |-> out_valid_i == '0 && in_full_i == '0)
	else begin
		$error("outputs were not idle right after reset");
		fail_cnt++;
	end

endmodule

bind edge_router edge_router_asserts chk (
	.clk, .rst_n_i, .local_addr_i,
	.head_i(head_flit), .head_valid_i(head_valid),
	.in_valid_i, .in_full_i(in_full_o), .out_valid_i(out_valid_o), .out_full_i,
	.grant_v_i(grant_v), .grant_e_i(grant_e), .grant_w_i(grant_w), .grant_l_i(grant_l)
);

// File: verification/edge_router_tb.sv
module edge_router_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import noc_pkg::*;

	localparam int    MAX_CYCLES = 2000;	// far above what all tests need.
	localparam addr_t HERE       = '{x: 4'd3, y: 4'd0};

	logic                 clk;
	logic                 rst_n;
	addr_t                local_addr;
	flit_t                in_flit  [NUM_PORTS-1:0];
	logic [NUM_PORTS-1:0] in_valid;
	logic [NUM_PORTS-1:0] in_full;
	flit_t                out_flit [NUM_PORTS-1:0];
	logic [NUM_PORTS-1:0] out_valid;
	logic [NUM_PORTS-1:0] out_full;

	// scoreboard, [input][output], with the edge at which each flit enters its buffer.
	flit_t exp_q   [NUM_PORTS][NUM_PORTS][$];
	int    stamp_q [NUM_PORTS][NUM_PORTS][$];
	int    rr_ptr  [NUM_PORTS];	// next favoured requester per output.
	int    cyc;
	bit    fixed_lat;
	string test_name;

	edge_router DUT (
		.clk, .rst_n_i(rst_n), .local_addr_i(local_addr),
		.in_flit_i(in_flit), .in_valid_i(in_valid), .in_full_o(in_full),
		.out_flit_o(out_flit), .out_valid_o(out_valid), .out_full_i(out_full)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	task automatic stop_fail(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	function automatic int route_of(input addr_t d);
		if (d.x > HERE.x) return PORT_E;
		if (d.x < HERE.x) return PORT_W;
		if (d.y > HERE.y) return PORT_N;
		return PORT_L;
	endfunction

	// any output an input may use, no u-turns.
	function automatic int pick_out(input int p);
		int o;
		do o = $urandom % NUM_PORTS;
		while (o == p || (o == PORT_N && p != PORT_L));
		return o;
	endfunction

	function automatic flit_t flit_toward(input int o);
		flit_t f;
		f.payload = PAYLOAD_W'($urandom);
		f.dest.y  = COORD_W'($urandom);
		case (o)
			PORT_E:  f.dest.x = HERE.x + 1 + COORD_W'($urandom % (15 - HERE.x));
			PORT_W:  f.dest.x = COORD_W'($urandom % HERE.x);
			PORT_N: begin
				f.dest.x = HERE.x;
				f.dest.y = HERE.y + 1 + COORD_W'($urandom % (15 - HERE.y));
			end
			default: f.dest = HERE;
		endcase
		return f;
	endfunction

	task automatic send(input int p, input flit_t f);
		in_valid[p] = 1'b1;
		in_flit[p]  = f;
		exp_q[p][route_of(f.dest)].push_back(f);
		stamp_q[p][route_of(f.dest)].push_back(cyc + 1);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
		in_valid = '0;
	endtask

	function automatic int pending();
		int n;
		n = 0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			for (int o = 0; o < NUM_PORTS; o++) n += exp_q[i][o].size();
		end
		return n;
	endfunction

	task automatic wait_drain();
		while (pending() != 0) next_cycle();
		next_cycle();
	endtask

	// the winner is the first waiting requester at or after the pointer.
	task automatic check_output(input int o, input flit_t got);
		int    src;
		int    idx;
		int    r;
		int    st;
		flit_t want;
		src = -1;
		for (int k = 0; k < 3 && src < 0; k++) begin
			idx = (rr_ptr[o] + k) % 3;
			r   = (idx < o) ? idx : idx + 1;	// requesters skip the output's own port.
			if (exp_q[r][o].size() != 0 && stamp_q[r][o][0] <= cyc - 1) begin
				src       = r;
				rr_ptr[o] = (idx + 1) % 3;
			end
		end
		if (src < 0) begin
			stop_fail($sformatf("output %0d sent flit %h that no input was waiting to send",
				o, got));
		end else begin
			want = exp_q[src][o].pop_front();
			st   = stamp_q[src][o].pop_front();
			if (got !== want) begin
				stop_fail($sformatf("** Error %s: output %0d expected %h actual %h",
					test_name, o, want, got));
			end else if (fixed_lat && cyc != st + 1) begin
				stop_fail($sformatf("** Error %s: output edge expected %0d actual %0d",
					test_name, st + 1, cyc));
			end
		end
	endtask

	always @(negedge clk) begin
		if (DUT.chk.fail_cnt != 0) begin
			stop_fail("an assertion on the router failed");
		end else if (cyc >= MAX_CYCLES) begin
			stop_fail($sformatf("timeout: the run did not end within %0d cycles", MAX_CYCLES));
		end else if (rst_n) begin
			for (int o = 0; o < NUM_PORTS; o++) begin
				if (out_valid[o]) check_output(o, out_flit[o]);
			end
		end
	end

	task automatic routing_test();
		int p;
		test_name = "xy_routing";
		fixed_lat = 1'b1;
		for (int n = 0; n < 24; n++) begin
			p = n % NUM_PORTS;
			send(p, flit_toward(pick_out(p)));
			next_cycle();
			wait_drain();
		end
	endtask

	task automatic contention_test();
		int srcs [3];
		int sent [3];
		test_name = "round_robin";
		fixed_lat = 1'b0;
		srcs = '{PORT_N, PORT_W, PORT_L};
		sent = '{0, 0, 0};
		while (sent[0] + sent[1] + sent[2] < 24) begin
			for (int s = 0; s < 3; s++) begin
				if (sent[s] < 8 && !in_full[srcs[s]]) begin
					send(srcs[s], flit_toward(PORT_E));
					sent[s]++;
				end
			end
			next_cycle();
		end
		wait_drain();
	endtask

	task automatic backpressure_test();
		int n;
		test_name = "back_pressure";
		fixed_lat = 1'b0;
		out_full[PORT_W] = 1'b1;
		n = 0;
		while (!in_full[PORT_E] && n <= FIFO_DEPTH) begin
			send(PORT_E, flit_toward(PORT_W));
			next_cycle();
			n++;
			if (out_valid[PORT_W]) stop_fail("west output sent a flit while downstream was full");
		end
		if (n != FIFO_DEPTH) begin
			stop_fail($sformatf("** Error %s: flits until full expected %0d actual %0d",
				test_name, FIFO_DEPTH, n));
		end
		out_full[PORT_W] = 1'b0;
		wait_drain();
	endtask

	// four inputs to four distinct outputs in one cycle.
	task automatic parallel_test();
		test_name = "parallel";
		fixed_lat = 1'b1;
		for (int r = 0; r < 4; r++) begin
			send(PORT_L, flit_toward(PORT_N));
			if (r % 2 == 0) begin
				send(PORT_N, flit_toward(PORT_E));
				send(PORT_E, flit_toward(PORT_W));
				send(PORT_W, flit_toward(PORT_L));
			end else begin
				send(PORT_N, flit_toward(PORT_W));
				send(PORT_E, flit_toward(PORT_L));
				send(PORT_W, flit_toward(PORT_E));
			end
			next_cycle();
			wait_drain();
		end
	endtask

	initial begin
		void'($urandom(32'ha568e11f));
		cyc        = 0;
		fixed_lat  = 1'b0;
		test_name  = "reset";
		rst_n      = 1'b0;
		local_addr = HERE;
		in_valid   = '0;
		out_full   = '0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			in_flit[p] = '0;
			rr_ptr[p]  = 0;
		end
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		next_cycle();
		routing_test();
		contention_test();
		backpressure_test();
		parallel_test();
		if (DUT.chk.fail_cnt == 0 && pending() == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			stop_fail("the run ended with errors or with flits still in flight");
		end
	end

endmodule

// File: project.f
src/noc_pkg.sv
src/route_calc.sv
src/rr_arbiter3.sv
src/edge_controller.sv
src/flit_fifo.sv
src/output_crossbar.sv
src/edge_router.sv
verification/edge_router_asserts.sv
verification/edge_router_tb.sv

// File: Bender.yml
package:
  name: edge_router

sources:
  - src/noc_pkg.sv
  - src/route_calc.sv
  - src/rr_arbiter3.sv
  - src/edge_controller.sv
  - src/flit_fifo.sv
  - src/output_crossbar.sv
  - src/edge_router.sv
  - target: test
    files:
      - verification/edge_router_asserts.sv
      - verification/edge_router_tb.sv
